// File: Bender.yml
package:
  name: icache_axi

sources:
  - include_dirs:
      - logic
    files:
      - logic/icache_pkg.sv
      - logic/icache_core.sv
      - logic/icache_refill.sv
      - logic/axi_read_master.sv
      - logic/icache_axi_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/tb_clock.sv
      - bench/axi_mem_model.sv
      - bench/icache_assert.sv
      - bench/icache_tb.sv

// File: bench/axi_mem_model.sv
/*
 * AXI read slave model with random AR and R delays
 * Word at byte address A holds the inverse of A above A
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module axi_mem_model (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              arvalid_i,
  output logic                              arready_o,
  input  logic [`ICACHE_ADDR_WIDTH-1:0]     araddr_i,
  input  logic [`ICACHE_AXI_LEN_WIDTH-1:0]  arlen_i,
  output logic                              rvalid_o,
  output logic [`ICACHE_AXI_DATA_WIDTH-1:0] rdata_o,
  output logic                              rlast_o
);

  // Idle cycles drawn as 0 up to the limit minus one
  localparam int unsigned ar_delay_span = 4;
  localparam int unsigned r_delay_span  = 3;

  integer seed;

  function automatic logic [`ICACHE_AXI_DATA_WIDTH-1:0] data_for(
    input logic [`ICACHE_ADDR_WIDTH-1:0] addr
  );
    logic [`ICACHE_ADDR_WIDTH-1:0] word_addr;
    word_addr = addr & ~32'h7;
    return {~word_addr, word_addr};
  endfunction

  // One burst at a time, all outputs change on the falling edge
  initial begin : serve
    logic [`ICACHE_ADDR_WIDTH-1:0]    addr;
    logic [`ICACHE_AXI_LEN_WIDTH-1:0] len;
    int unsigned                      gap;
    seed      = 32'h0011_b9e9;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    rdata_o   = '0;
    rlast_o   = 1'b0;
    forever begin
      @(negedge clk_i);
      if (rst_ni && arvalid_i) begin
        gap = $unsigned($random(seed)) % ar_delay_span;
        repeat (gap) @(negedge clk_i);
        // arvalid holds its fields until the handshake
        addr      = araddr_i;
        len       = arlen_i;
        arready_o = 1'b1;
        @(negedge clk_i);
        arready_o = 1'b0;
        for (int beat = 0; beat <= int'(len); beat++) begin
          gap = $unsigned($random(seed)) % r_delay_span;
          repeat (gap) @(negedge clk_i);
          rvalid_o = 1'b1;
          rdata_o  = data_for(addr + 32'(beat) * 8);
          rlast_o  = (beat == int'(len));
          @(negedge clk_i);
          rvalid_o = 1'b0;
          rlast_o  = 1'b0;
        end
      end
    end
  end

endmodule

// File: bench/icache_assert.sv
/*
 * Concurrent checks bound to the cache top level
 * Reset state, AR stability and format, one outstanding burst,
 * burst alignment, R always ready
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_assert
  import icache_pkg::*;
(
  input logic                             clk_i,
  input logic                             rst_ni,
  input logic                             fetch_ready_o,
  input logic                             fetch_valid_o,
  input logic                             miss_o,
  input logic                             arvalid_o,
  input logic                             arready_i,
  input logic [`ICACHE_ADDR_WIDTH-1:0]    araddr_o,
  input logic [`ICACHE_AXI_LEN_WIDTH-1:0] arlen_o,
  input logic [2:0]                       arsize_o,
  input logic [1:0]                       arburst_o,
  input logic                             rvalid_i,
  input logic                             rready_o,
  input logic                             rlast_i
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  logic [1:0]  outstanding_q;
  fetch_addr_t ar_addr;

  assign ar_addr.raw = araddr_o;

  // AR handshakes minus completed bursts
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= '0;
    end else if (arvalid_o && arready_i) begin
      outstanding_q <= outstanding_q + 2'd1;
    end else if (rvalid_i && rlast_i) begin
      outstanding_q <= outstanding_q - 2'd1;
    end
  end

  reset_state: assert property (@(posedge clk_i) $rose(rst_ni) |->
      !fetch_valid_o && !miss_o && !arvalid_o && fetch_ready_o)
    else begin
      $error("outputs not idle when reset is released");
      fail_count++;
    end

  // Held address must not move before acceptance
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arlen_o))
    else begin
      $error("AR channel changed before arready");
      fail_count++;
    end

  single_burst: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arvalid_o |-> outstanding_q == '0)
    else begin
      $error("new AR issued while a burst is still open");
      fail_count++;
    end

  // Bursts start on a line, single beats on a word
  ar_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arvalid_o |-> ar_addr.fields.byte_off == '0 &&
      (arlen_o == '0 || ar_addr.fields.word == '0))
    else begin
      $error("AR address not aligned to its burst");
      fail_count++;
    end

  // 8-byte beats, INCR addressing
  ar_format: assert property (@(posedge clk_i) disable iff (!rst_ni)
      arvalid_o |-> arsize_o == 3'd3 && arburst_o == 2'b01)
    else begin
      $error("AR size or burst type is not 8-byte INCR");
      fail_count++;
    end

  // No back-pressure on R
  r_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
      rready_o)
    else begin
      $error("rready dropped while out of reset");
      fail_count++;
    end

  miss_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
      miss_o |=> !miss_o)
    else begin
      $error("miss held for more than one cycle");
      fail_count++;
    end

endmodule

bind icache_axi_top icache_assert assert_inst (.*);

// File: bench/icache_tb.sv
/*
 * Testbench for the AXI instruction cache
 * Reference tag model, fetch checks per test, timeout and final verdict
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_tb
  import icache_pkg::*;
();

  localparam int unsigned sets = `ICACHE_NUM_SETS;
  localparam int unsigned dw   = `ICACHE_AXI_DATA_WIDTH;
  localparam int unsigned aw   = `ICACHE_ADDR_WIDTH;
  localparam logic [aw-1:0] base_addr = 32'h8000_0000;

  // Bus address alignment, 8-byte words and 32-byte lines
  localparam logic [aw-1:0] word_mask = ~32'h7;
  localparam logic [aw-1:0] line_mask = ~32'h1F;

  // About 200 fetches at up to 40 cycles each, plus margin
  localparam int unsigned fetch_budget     = 200;
  localparam int unsigned cycles_per_fetch = 40;
  localparam int unsigned max_cycles = fetch_budget * cycles_per_fetch + 2000;

  logic                             clk;
  logic                             rst_n;
  logic                             flush;
  logic                             fetch_req;
  fetch_addr_t                      fetch_addr;
  logic                             fetch_nc;
  logic                             fetch_ready;
  logic                             fetch_valid;
  logic [dw-1:0]                    fetch_data;
  logic                             miss;
  logic                             arvalid;
  logic                             arready;
  logic [aw-1:0]                    araddr;
  logic [`ICACHE_AXI_LEN_WIDTH-1:0] arlen;
  logic [2:0]                       arsize;
  logic [1:0]                       arburst;
  logic                             rvalid;
  logic                             rready;
  logic [dw-1:0]                    rdata;
  logic                             rlast;

  // Reference contents of the direct-mapped cache
  logic                 model_valid [sets];
  logic [tag_width-1:0] model_tag   [sets];

  int unsigned                      ar_count;
  int unsigned                      miss_count;
  logic [aw-1:0]                    last_araddr;
  logic [`ICACHE_AXI_LEN_WIDTH-1:0] last_arlen;

  // AR bursts the reference model has asked for so far
  int unsigned exp_ar_count;

  int unsigned cycle_count = 0;
  int unsigned error_count = 0;
  int unsigned check_count = 0;
  int unsigned test_count  = 0;
  int unsigned test_fetches;
  int unsigned test_err_base;
  integer      addr_seed;

  tb_clock clock_inst (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  icache_axi_top icache_axi_top_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .flush_i       (flush),
    .fetch_req_i   (fetch_req),
    .fetch_addr_i  (fetch_addr),
    .fetch_nc_i    (fetch_nc),
    .fetch_ready_o (fetch_ready),
    .fetch_valid_o (fetch_valid),
    .fetch_data_o  (fetch_data),
    .miss_o        (miss),
    .arvalid_o     (arvalid),
    .arready_i     (arready),
    .araddr_o      (araddr),
    .arlen_o       (arlen),
    .arsize_o      (arsize),
    .arburst_o     (arburst),
    .rvalid_i      (rvalid),
    .rready_o      (rready),
    .rdata_i       (rdata),
    .rlast_i       (rlast)
  );

  axi_mem_model mem_inst (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .arvalid_i (arvalid),
    .arready_o (arready),
    .araddr_i  (araddr),
    .arlen_i   (arlen),
    .rvalid_o  (rvalid),
    .rdata_o   (rdata),
    .rlast_o   (rlast)
  );

  // Bus and miss activity, counted on the sampling edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ar_count    <= 0;
      miss_count  <= 0;
      last_araddr <= '0;
      last_arlen  <= '0;
    end else begin
      if (arvalid && arready) begin
        ar_count    <= ar_count + 1;
        last_araddr <= araddr;
        last_arlen  <= arlen;
      end
      if (miss) begin
        miss_count <= miss_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= max_cycles) begin
      $display("Timeout after %0d cycles, the DUT stopped answering", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Memory rule: inverse address above the word address
  function automatic logic [dw-1:0] word_at(input logic [aw-1:0] addr);
    logic [aw-1:0] word_addr;
    word_addr = addr & ~32'h7;
    return {~word_addr, word_addr};
  endfunction

  task automatic expect_value(input string name, input logic [dw-1:0] exp,
                              input logic [dw-1:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic expect_true(input string name, input logic cond, input string what);
    check_count++;
    assert (cond === 1'b1) else begin
      $display("%s: %s", name, what);
      error_count++;
    end
  endtask

  // One fetch, hit or miss decided by the reference model
  task automatic fetch_check(input string name, input logic [aw-1:0] addr, input logic nc);
    fetch_addr_t   fa;
    logic [aw-1:0] exp_ar;
    logic          expect_hit;
    int unsigned   miss_before;
    fa.raw     = addr;
    expect_hit = !nc && model_valid[fa.fields.index]
               && (model_tag[fa.fields.index] == fa.fields.tag);
    // Single beat at the word, full burst from the line start
    exp_ar = nc ? (addr & word_mask) : (addr & line_mask);
    while (!fetch_ready) @(negedge clk);
    miss_before = miss_count;
    fetch_req   = 1'b1;
    fetch_addr  = fa;
    fetch_nc    = nc;
    @(negedge clk);
    fetch_req = 1'b0;
    if (expect_hit) begin
      expect_true(name, fetch_valid, "no data one cycle after a hit");
      expect_true(name, !miss, "miss raised on a hit");
      // Earlier hits must not have left a burst behind
      expect_value(name, dw'(exp_ar_count), dw'(ar_count));
    end else begin
      expect_true(name, !fetch_ready, "still ready in the cycle after a miss");
      while (!fetch_valid) @(negedge clk);
      exp_ar_count++;
      expect_value(name, dw'(exp_ar_count), dw'(ar_count));
      expect_value(name, dw'(exp_ar), dw'(last_araddr));
      expect_value(name, nc ? '0 : dw'(`ICACHE_BEATS - 1), dw'(last_arlen));
      expect_value(name, dw'(miss_before + (nc ? 0 : 1)), dw'(miss_count));
      if (!nc) begin
        model_valid[fa.fields.index] = 1'b1;
        model_tag[fa.fields.index]   = fa.fields.tag;
      end
    end
    expect_value(name, word_at(addr), fetch_data);
    test_fetches++;
  endtask

  task automatic flush_all();
    while (!fetch_ready) @(negedge clk);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    for (int s = 0; s < sets; s++) begin
      model_valid[s] = 1'b0;
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %-10s fetches %0d errors %0d", name, test_fetches,
             error_count - test_err_base);
    test_fetches  = 0;
    test_err_base = error_count;
  endtask

  initial begin
    logic [aw-1:0] raddr;
    logic          rnc;
    int unsigned   assert_fails;
    flush         = 1'b0;
    fetch_req     = 1'b0;
    fetch_addr    = '0;
    fetch_nc      = 1'b0;
    addr_seed     = 32'h0011_b9e9;
    test_fetches  = 0;
    test_err_base = 0;
    exp_ar_count  = 0;
    for (int s = 0; s < sets; s++) begin
      model_valid[s] = 1'b0;
      model_tag[s]   = '0;
    end
    @(negedge clk);
    while (!rst_n) @(negedge clk);

    // Each line once, at a different word
    for (int l = 0; l < 8; l++) begin
      fetch_check("cold_miss", base_addr + 32'(l) * 32 + 32'(l % 4) * 8, 1'b0);
    end
    finish_test("cold_miss");

    // Back-to-back hits over every word
    for (int l = 0; l < 8; l++) begin
      for (int w = 0; w < 4; w++) begin
        fetch_check("hits", base_addr + 32'(l) * 32 + 32'(w) * 8, 1'b0);
      end
    end
    finish_test("hits");

    // Bypass of an uncached line, then a real miss on it
    fetch_check("bypass", base_addr + 32'h410, 1'b1);
    fetch_check("bypass", base_addr + 32'h410, 1'b0);
    fetch_check("bypass", base_addr + 32'h418, 1'b0);
    fetch_check("bypass", base_addr + 32'h030, 1'b1);
    finish_test("bypass");

    flush_all();
    for (int l = 1; l < 8; l++) begin
      fetch_check("flush", base_addr + 32'(l) * 32, 1'b0);
      fetch_check("flush", base_addr + 32'(l) * 32 + 8, 1'b0);
    end
    finish_test("flush");

    // Mixed traffic under random bus delays
    for (int i = 0; i < 120; i++) begin
      raddr = base_addr + ($unsigned($random(addr_seed)) & 32'h0000_0FF8);
      rnc   = (($unsigned($random(addr_seed)) & 32'h7) == 0);
      fetch_check("random", raddr, rnc);
    end
    finish_test("random");

    assert_fails = icache_axi_top_inst.assert_inst.fail_count;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_count, check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: bench/tb_clock.sv
/*
 * Testbench clock and power-on reset generator
 */

`timescale 1ns/1ps

module tb_clock #(
  parameter int unsigned period_ns    = 100,
  parameter int unsigned reset_cycles = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // Released on a falling edge, away from the sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: logic/axi_read_master.sv
/*
 * Read-only AXI4 master
 * Registered AR channel held until accepted, R beats forwarded
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module axi_read_master (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Request side
  input  logic                              rd_req_i,
  output logic                              rd_gnt_o,
  input  logic [`ICACHE_ADDR_WIDTH-1:0]     rd_addr_i,
  input  logic [`ICACHE_AXI_LEN_WIDTH-1:0]  rd_len_i,
  output logic                              rd_valid_o,
  output logic                              rd_last_o,
  output logic [`ICACHE_AXI_DATA_WIDTH-1:0] rd_data_o,
  // AR channel
  output logic                              arvalid_o,
  input  logic                              arready_i,
  output logic [`ICACHE_ADDR_WIDTH-1:0]     araddr_o,
  output logic [`ICACHE_AXI_LEN_WIDTH-1:0]  arlen_o,
  output logic [2:0]                        arsize_o,
  output logic [1:0]                        arburst_o,
  // R channel
  input  logic                              rvalid_i,
  output logic                              rready_o,
  input  logic [`ICACHE_AXI_DATA_WIDTH-1:0] rdata_i,
  input  logic                              rlast_i
);

  // INCR burst type
  localparam logic [1:0] burst_incr = 2'b01;

  // Full bus width per beat
  localparam logic [2:0] size_full = 3'($clog2(`ICACHE_AXI_DATA_WIDTH / 8));

  logic                             arvalid_q;
  logic [`ICACHE_ADDR_WIDTH-1:0]    araddr_q;
  logic [`ICACHE_AXI_LEN_WIDTH-1:0] arlen_q;
  logic                             ar_load;

  // Take a new request only when the AR slot is empty
  assign ar_load = rd_req_i & ~arvalid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      arvalid_q <= 1'b0;
    end else if (ar_load) begin
      arvalid_q <= 1'b1;
    end else if (arready_i) begin
      arvalid_q <= 1'b0;
    end
  end

  // Fields stay put while arvalid is high
  always_ff @(posedge clk_i) begin
    if (ar_load) begin
      araddr_q <= rd_addr_i;
      arlen_q  <= rd_len_i;
    end
  end

  assign arvalid_o = arvalid_q;
  assign araddr_o  = araddr_q;
  assign arlen_o   = arlen_q;
  assign arsize_o  = size_full;
  assign arburst_o = burst_incr;

  // Grant on the address handshake
  assign rd_gnt_o = arvalid_q & arready_i;

  // No R back-pressure
  assign rready_o   = 1'b1;
  assign rd_valid_o = rvalid_i;
  assign rd_last_o  = rvalid_i & rlast_i;
  assign rd_data_o  = rdata_i;

endmodule

// File: logic/icache_axi_top.sv
/*
 * Instruction cache with AXI refill
 * Cache core, refill bridge and read-only AXI master
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_axi_top
  import icache_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  // Fetch port
  input  logic                              fetch_req_i,
  input  fetch_addr_t                       fetch_addr_i,
  input  logic                              fetch_nc_i,
  output logic                              fetch_ready_o,
  output logic                              fetch_valid_o,
  output logic [`ICACHE_AXI_DATA_WIDTH-1:0] fetch_data_o,
  output logic                              miss_o,
  // AXI AR
  output logic                              arvalid_o,
  input  logic                              arready_i,
  output logic [`ICACHE_ADDR_WIDTH-1:0]     araddr_o,
  output logic [`ICACHE_AXI_LEN_WIDTH-1:0]  arlen_o,
  output logic [2:0]                        arsize_o,
  output logic [1:0]                        arburst_o,
  // AXI R
  input  logic                              rvalid_i,
  output logic                              rready_o,
  input  logic [`ICACHE_AXI_DATA_WIDTH-1:0] rdata_i,
  input  logic                              rlast_i
);

  // Core to bridge
  logic                          mem_req;
  logic                          mem_ack;
  fetch_addr_t                   mem_addr;
  logic                          mem_nc;
  logic                          rtrn_vld;
  logic [`ICACHE_LINE_WIDTH-1:0] rtrn_line;

  // Bridge to master
  logic                              rd_req;
  logic                              rd_gnt;
  logic [`ICACHE_ADDR_WIDTH-1:0]     rd_addr;
  logic [`ICACHE_AXI_LEN_WIDTH-1:0]  rd_len;
  logic                              rd_valid;
  logic                              rd_last;
  logic [`ICACHE_AXI_DATA_WIDTH-1:0] rd_data;

  icache_core core_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_nc_i    (fetch_nc_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_data_o  (fetch_data_o),
    .miss_o        (miss_o),
    .mem_req_o     (mem_req),
    .mem_ack_i     (mem_ack),
    .mem_addr_o    (mem_addr),
    .mem_nc_o      (mem_nc),
    .rtrn_vld_i    (rtrn_vld),
    .rtrn_line_i   (rtrn_line)
  );

  icache_refill refill_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mem_req_i   (mem_req),
    .mem_addr_i  (mem_addr),
    .mem_nc_i    (mem_nc),
    .mem_ack_o   (mem_ack),
    .rtrn_vld_o  (rtrn_vld),
    .rtrn_line_o (rtrn_line),
    .rd_req_o    (rd_req),
    .rd_gnt_i    (rd_gnt),
    .rd_addr_o   (rd_addr),
    .rd_len_o    (rd_len),
    .rd_valid_i  (rd_valid),
    .rd_last_i   (rd_last),
    .rd_data_i   (rd_data)
  );

  axi_read_master master_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rd_req_i   (rd_req),
    .rd_gnt_o   (rd_gnt),
    .rd_addr_i  (rd_addr),
    .rd_len_i   (rd_len),
    .rd_valid_o (rd_valid),
    .rd_last_o  (rd_last),
    .rd_data_o  (rd_data),
    .arvalid_o  (arvalid_o),
    .arready_i  (arready_i),
    .araddr_o   (araddr_o),
    .arlen_o    (arlen_o),
    .arsize_o   (arsize_o),
    .arburst_o  (arburst_o),
    .rvalid_i   (rvalid_i),
    .rready_o   (rready_o),
    .rdata_i    (rdata_i),
    .rlast_i    (rlast_i)
  );

endmodule

// File: logic/icache_core.sv
/*
 * Direct-mapped instruction cache core
 * Flip-flop tag, valid and data arrays, miss FSM, non-cacheable bypass, flush
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_core
  import icache_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // Fetch side
  input  logic                          fetch_req_i,
  input  fetch_addr_t                   fetch_addr_i,
  input  logic                          fetch_nc_i,
  output logic                          fetch_ready_o,
  output logic                          fetch_valid_o,
  output logic [`ICACHE_AXI_DATA_WIDTH-1:0] fetch_data_o,
  output logic                          miss_o,
  // Refill side
  output logic                          mem_req_o,
  input  logic                          mem_ack_i,
  output fetch_addr_t                   mem_addr_o,
  output logic                          mem_nc_o,
  input  logic                          rtrn_vld_i,
  input  logic [`ICACHE_LINE_WIDTH-1:0] rtrn_line_i
);

  localparam int unsigned sets  = `ICACHE_NUM_SETS;
  localparam int unsigned beats = `ICACHE_BEATS;
  localparam int unsigned dw    = `ICACHE_AXI_DATA_WIDTH;

  // FSM encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_req  = 2'd1;
  localparam logic [1:0] st_wait = 2'd2;

  logic [1:0] state_q, state_d;

  // Storage arrays
  logic [sets-1:0]                    valid_q;
  logic [sets-1:0][tag_width-1:0]     tag_q;
  logic [sets-1:0][beats-1:0][dw-1:0] data_q;

  // Request captured at acceptance
  fetch_addr_t req_addr_q;
  logic        req_nc_q;

  logic                     accept;
  logic                     hit;
  logic                     fill;
  logic                     rtrn_done;
  logic [beats-1:0][dw-1:0] rtrn_words;

  logic          fetch_valid_q;
  logic [dw-1:0] fetch_data_q;
  logic          miss_q;

  // Only idle accepts new fetches
  assign fetch_ready_o = (state_q == st_idle);
  assign accept        = fetch_req_i & fetch_ready_o;

  // Tag compare on the incoming address
  // A flush in the same cycle forces a miss
  assign hit = valid_q[fetch_addr_i.fields.index]
             & (tag_q[fetch_addr_i.fields.index] == fetch_addr_i.fields.tag)
             & ~fetch_nc_i & ~flush_i;

  // Returned line split into bus words
  assign rtrn_words = rtrn_line_i;
  assign rtrn_done  = (state_q == st_wait) & rtrn_vld_i;
  // Bypassed returns never allocate
  assign fill       = rtrn_done & ~req_nc_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (accept && !hit) state_d = st_req;
      // Ack comes back in the same cycle
      st_req:  if (mem_ack_i) state_d = st_wait;
      st_wait: if (rtrn_vld_i) state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  // Control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= st_idle;
      valid_q       <= '0;
      fetch_valid_q <= 1'b0;
      miss_q        <= 1'b0;
    end else begin
      state_q       <= state_d;
      fetch_valid_q <= (accept & hit) | rtrn_done;
      // One pulse per cacheable miss
      miss_q        <= accept & ~hit & ~fetch_nc_i;
      if (flush_i && fetch_ready_o) begin
        valid_q <= '0;
      end else if (fill) begin
        valid_q[req_addr_q.fields.index] <= 1'b1;
      end
    end
  end

  // Arrays and payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= fetch_addr_i;
      req_nc_q   <= fetch_nc_i;
    end
    if (fill) begin
      tag_q[req_addr_q.fields.index]  <= req_addr_q.fields.tag;
      data_q[req_addr_q.fields.index] <= rtrn_words;
    end
    if (accept && hit) begin
      fetch_data_q <= data_q[fetch_addr_i.fields.index][fetch_addr_i.fields.word];
    end else if (rtrn_done) begin
      // Single-beat bypass data sits at word 0
      fetch_data_q <= req_nc_q ? rtrn_words[0] : rtrn_words[req_addr_q.fields.word];
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_data_o  = fetch_data_q;
  assign miss_o        = miss_q;

  // Refill request, held for exactly one cycle
  assign mem_req_o  = (state_q == st_req);
  assign mem_addr_o = req_addr_q;
  assign mem_nc_o   = req_nc_q;

endmodule

// File: logic/icache_pkg.sv
/*
 * Fetch-address field widths, the tag/index/offset field struct
 * and the raw/fields union shared by the cache, the bridge and the checks
 */

`include "icache_settings.svh"

package icache_pkg;

  // Byte offset inside one bus word
  localparam int unsigned byte_width = $clog2(`ICACHE_AXI_DATA_WIDTH / 8);

  // Word offset inside one line
  localparam int unsigned word_width = $clog2(`ICACHE_BEATS);

  // Set index
  localparam int unsigned index_width = $clog2(`ICACHE_NUM_SETS);

  // Everything above index and offsets is tag
  localparam int unsigned tag_width =
    `ICACHE_ADDR_WIDTH - index_width - word_width - byte_width;

  // Lookup view of a fetch address, MSB first
  typedef struct packed {
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] index;
    logic [word_width-1:0]  word;
    logic [byte_width-1:0]  byte_off;
  } fetch_addr_fields_t;

  // Same word seen raw for the bus side
  // or split into fields for the tag lookup
  typedef union packed {
    logic [`ICACHE_ADDR_WIDTH-1:0] raw;
    fetch_addr_fields_t            fields;
  } fetch_addr_t;

endpackage

// File: logic/icache_refill.sv
/*
 * Refill bridge between the cache core and the AXI read master
 * Holds the miss request until granted, picks the burst length
 * and assembles the returned beats into one line
 */

`timescale 1ns/1ps

`include "icache_settings.svh"

module icache_refill
  import icache_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Cache side
  input  logic                             mem_req_i,
  input  fetch_addr_t                      mem_addr_i,
  input  logic                             mem_nc_i,
  output logic                             mem_ack_o,
  output logic                             rtrn_vld_o,
  output logic [`ICACHE_LINE_WIDTH-1:0]    rtrn_line_o,
  // Read master side
  output logic                             rd_req_o,
  input  logic                             rd_gnt_i,
  output logic [`ICACHE_ADDR_WIDTH-1:0]    rd_addr_o,
  output logic [`ICACHE_AXI_LEN_WIDTH-1:0] rd_len_o,
  input  logic                             rd_valid_i,
  input  logic                             rd_last_i,
  input  logic [`ICACHE_AXI_DATA_WIDTH-1:0] rd_data_i
);

  localparam int unsigned beats = `ICACHE_BEATS;
  localparam int unsigned dw    = `ICACHE_AXI_DATA_WIDTH;

  logic        req_pend_q, req_pend_d;
  fetch_addr_t addr_q, addr_d;
  logic        nc_q, nc_d;
  fetch_addr_t bus_addr;

  // Set until the first beat of a burst lands
  logic first_q, first_d;

  logic [beats-1:0][dw-1:0] shift_q, shift_d;

  // Pending until the AR handshake
  assign req_pend_d = ~rd_gnt_i & (mem_req_i | req_pend_q);

  // Capture address and type on a new request
  assign addr_d = mem_req_i ? mem_addr_i : addr_q;
  assign nc_d   = mem_req_i ? mem_nc_i : nc_q;

  // New or still pending request
  assign rd_req_o = mem_req_i | req_pend_q;

  // Word aligned for bypass, line aligned for a refill
  always_comb begin
    bus_addr                 = addr_d;
    bus_addr.fields.byte_off = '0;
    if (!nc_d) begin
      bus_addr.fields.word = '0;
    end
  end

  assign rd_addr_o = bus_addr.raw;

  // One beat for bypass, full line otherwise
  assign rd_len_o = nc_d ? '0 : (`ICACHE_AXI_LEN_WIDTH)'(beats - 1);

  // Implicit ack, the core never waits
  assign mem_ack_o = mem_req_i;

  // Beats enter from the top and move down
  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (rd_valid_i) begin
      first_d = rd_last_i;
      shift_d = {rd_data_i, shift_q[beats-1:1]};
      // Lone beat goes to offset 0
      if (first_q) begin
        shift_d[0] = rd_data_i;
      end
    end
  end

  // Line goes back with the last beat
  assign rtrn_vld_o  = rd_valid_i & rd_last_i;
  assign rtrn_line_o = shift_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_pend_q <= 1'b0;
      first_q    <= 1'b1;
    end else begin
      req_pend_q <= req_pend_d;
      first_q    <= first_d;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    addr_q  <= addr_d;
    nc_q    <= nc_d;
    shift_q <= shift_d;
  end

endmodule

// File: logic/icache_settings.svh
/*
 * Width and geometry macros for the instruction cache and its AXI refill path
 */

`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Physical fetch address
`define ICACHE_ADDR_WIDTH 32

// One cache line, refilled as a single burst
`define ICACHE_LINE_WIDTH 256

// AXI data bus, also the width of one fetched word
`define ICACHE_AXI_DATA_WIDTH 64

// Direct-mapped, one line per set
`define ICACHE_NUM_SETS 16

// Beats needed for one line refill
`define ICACHE_BEATS (`ICACHE_LINE_WIDTH / `ICACHE_AXI_DATA_WIDTH)

// AXI4 ARLEN field width
`define ICACHE_AXI_LEN_WIDTH 8

`endif

// File: vlog.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_core.sv
logic/icache_refill.sv
logic/axi_read_master.sv
logic/icache_axi_top.sv
bench/tb_clock.sv
bench/axi_mem_model.sv
bench/icache_assert.sv
bench/icache_tb.sv
